/* Bender.yml */
package:
  name: slurm16_cpu

sources:
  - files:
      - slurm16_pkg.sv
      - slurm16_cpu_memory_interface.sv
      - slurm16_cpu_sequencer.sv
      - slurm16_cpu_register_file.sv
      - slurm16_cpu_execute.sv
      - slurm16_cpu_port_interface.sv
      - slurm16_cpu_top.sv
  - target: test
    files:
      - tb_slurm16_memory.sv
      - tb_slurm16_cpu.sv

/* all.f */
slurm16_pkg.sv
slurm16_cpu_memory_interface.sv
slurm16_cpu_sequencer.sv
slurm16_cpu_register_file.sv
slurm16_cpu_execute.sv
slurm16_cpu_port_interface.sv
slurm16_cpu_top.sv
tb_slurm16_memory.sv
tb_slurm16_cpu.sv

/* slurm16_cpu_execute.sv */
/*
 * CPU execute unit.
 * Decodes the instruction word, runs the ALU, keeps the Z flag,
 * decides on jumps and picks the writeback source.
 */

module slurm16_cpu_execute import slurm16_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,

	input  word_t    instr,
	input  logic     exec_en,
	input  word_t    a_data,
	input  word_t    b_data,
	input  word_t    mem_rdata,
	input  word_t    port_rdata,
	input  logic     wb_from_mem,

	output reg_sel_t a_sel,
	output reg_sel_t b_sel,
	output reg_sel_t wr_sel,
	output word_t    wr_data,
	output logic     is_mem_op,
	output logic     is_store,
	output logic     is_port_op,
	output logic     is_port_write,
	output logic     is_halt,
	output logic     take_jump,
	output addr_t    jump_target,
	output addr_t    load_addr,
	output word_t    store_data,
	output addr_t    port_addr,
	output word_t    port_wdata
);

	opcode_t  op;
	reg_sel_t rd_sel;
	logic     is_alu;
	logic     writes_rd;
	logic     z_flag;
	word_t    alu_result;

	// ------------------------------------------------------------
	// Field decode
	// ------------------------------------------------------------

	// Layout is op[15:12], rd[11:8], then ra[7:4] and rb[3:0] or imm[7:0].
	assign op = opcode_t'(instr[15:12]);
	assign rd_sel = instr[11:8];
	assign a_sel = instr[7:4];
	assign b_sel = instr[3:0];

	assign is_alu = (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) ||
		(op == OP_OR) || (op == OP_XOR);
	assign writes_rd = is_alu || (op == OP_LDI) || (op == OP_LD) || (op == OP_IN);

	assign is_mem_op = (op == OP_LD) || (op == OP_ST);
	assign is_store = (op == OP_ST);
	assign is_port_op = (op == OP_IN) || (op == OP_OUT);
	assign is_port_write = (op == OP_OUT);
	assign is_halt = (op == OP_HALT);

	// Every address comes from register ra and every store value from rb.
	assign load_addr = a_data;
	assign jump_target = a_data;
	assign port_addr = a_data;
	assign store_data = b_data;
	assign port_wdata = b_data;

	// ------------------------------------------------------------
	// ALU and flags
	// ------------------------------------------------------------

	always_comb begin
		case (op)
			OP_ADD:  alu_result = a_data + b_data;
			OP_SUB:  alu_result = a_data - b_data;
			OP_AND:  alu_result = a_data & b_data;
			OP_OR:   alu_result = a_data | b_data;
			default: alu_result = a_data ^ b_data;
		endcase
	end

	// Only ALU ops touch Z, so a JZ tests the last ALU result.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			z_flag <= 1'b0;
		else if (exec_en && is_alu)
			z_flag <= (alu_result == '0);
	end

	assign take_jump = (op == OP_JMP) || ((op == OP_JZ) && z_flag);

	// ------------------------------------------------------------
	// Writeback source
	// ------------------------------------------------------------

	// Instructions without a result write register ra back with its own
	// value, so the sequencer's write strobe needs no opcode knowledge.
	assign wr_sel = writes_rd ? rd_sel : a_sel;

	always_comb begin
		if (wb_from_mem)
			wr_data = mem_rdata;
		else if (is_alu)
			wr_data = alu_result;
		else if (op == OP_LDI)
			wr_data = {{(BITS - 8){1'b0}}, instr[7:0]};
		else if (op == OP_IN)
			wr_data = port_rdata;
		else
			wr_data = a_data;
	end

endmodule

/* slurm16_cpu_memory_interface.sv */
/*
 * CPU memory interface.
 * Places fetch, load and store requests on the memory bus, holds them
 * until the bus answers with ready and hands read data back to the core.
 */

module slurm16_cpu_memory_interface import slurm16_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,

	// Request side, driven by the sequencer.
	input  logic  mem_req,
	input  logic  mem_write,
	input  addr_t mem_addr,
	input  word_t mem_wdata,
	output word_t mem_rdata,
	output logic  mem_done,

	// Memory bus.
	output addr_t memory_address,
	output word_t memory_out,
	input  word_t memory_in,
	output logic  memory_valid,
	output logic  memory_wr,
	input  logic  memory_ready
);

	logic launch;
	logic complete;

	// A new transfer starts when the bus is idle and the sequencer asks.
	// In the mem_done cycle the old request is still up, so it is skipped.
	assign launch = mem_req && !memory_valid && !mem_done;
	assign complete = memory_valid && memory_ready;

	// ------------------------------------------------------------
	// Bus control
	// ------------------------------------------------------------

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			memory_valid <= 1'b0;
			memory_wr <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= complete;
			if (complete) begin
				memory_valid <= 1'b0;
				memory_wr <= 1'b0;
			end else if (launch) begin
				memory_valid <= 1'b1;
				memory_wr <= mem_write;
			end
		end
	end

	// Address and write data are latched once and held for the whole
	// transfer, however long ready stays low.
	always_ff @(posedge CLK) begin
		if (launch) begin
			memory_address <= mem_addr;
			memory_out <= mem_wdata;
		end
		if (complete)
			mem_rdata <= memory_in;
	end

	// The request must not move while the bus is stalling it.
	property p_request_held;
		@(posedge CLK) disable iff (!rst_n)
		memory_valid && !memory_ready |=> memory_valid && $stable(memory_address) &&
			$stable(memory_wr) && $stable(memory_out);
	endproperty

	a_request_held: assert property (p_request_held)
		else $error("memory request changed while memory_ready was low");

endmodule

/* slurm16_cpu_port_interface.sv */
/*
 * CPU port interface.
 * Registers the port address and data, issues one rd or wr strobe
 * per port instruction and captures the returned port input.
 */

module slurm16_cpu_port_interface import slurm16_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,

	input  logic  port_go,
	input  logic  is_port_write,
	input  addr_t port_addr,
	input  word_t port_wdata,
	input  word_t port_in,

	output word_t port_rdata,
	output logic  port_done,
	output addr_t port_address,
	output word_t port_out,
	output logic  port_rd,
	output logic  port_wr
);

	// The strobe follows port_go by one cycle and lasts one cycle.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			port_rd <= 1'b0;
			port_wr <= 1'b0;
			port_done <= 1'b0;
		end else begin
			port_rd <= port_go && !is_port_write;
			port_wr <= port_go && is_port_write;
			port_done <= port_go;
		end
	end

	// Port input is sampled at the edge that closes the rd strobe.
	always_ff @(posedge CLK) begin
		if (port_go) begin
			port_address <= port_addr;
			port_out <= port_wdata;
		end
		if (port_rd)
			port_rdata <= port_in;
	end

	// The two strobes are never high in the same cycle.
	a_no_overlap: assert property (@(posedge CLK) disable iff (!rst_n) !(port_rd && port_wr))
		else $error("port_rd and port_wr high together");

endmodule

/* slurm16_cpu_register_file.sv */
/*
 * CPU register file.
 * Sixteen 16-bit registers, two asynchronous read ports and one
 * synchronous write port.
 */

module slurm16_cpu_register_file import slurm16_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,

	input  logic     we,
	input  reg_sel_t wr_sel,
	input  word_t    wr_data,

	input  reg_sel_t a_sel,
	input  reg_sel_t b_sel,
	output word_t    a_data,
	output word_t    b_data
);

	localparam int NUM_REGS = 1 << REGISTER_BITS;

	word_t regs [NUM_REGS];

	// All registers start from zero after reset.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// Reads see the current contents, so operands are ready in the
	// execute cycle right after the fetch.
	assign a_data = regs[a_sel];
	assign b_data = regs[b_sel];

endmodule

/* slurm16_cpu_sequencer.sv */
/*
 * CPU sequencer.
 * Fetch/execute state machine with the program counter, the
 * instruction register and the halt state.
 */

module slurm16_cpu_sequencer import slurm16_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,

	input  word_t mem_rdata,
	input  logic  mem_done,
	input  logic  port_done,
	input  logic  is_mem_op,
	input  logic  is_store,
	input  logic  is_port_op,
	input  logic  is_halt,
	input  logic  take_jump,
	input  addr_t jump_target,
	input  addr_t load_addr,
	input  word_t store_data,

	output logic  mem_req,
	output logic  mem_write,
	output addr_t mem_addr,
	output word_t mem_wdata,
	output word_t instr,
	output logic  exec_en,
	output logic  port_go,
	output logic  reg_we,
	output logic  wb_from_mem,
	output logic  halted
);

	seq_state_t state;
	addr_t pc;

	// ------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
			pc <= RESET_PC;
			instr <= '0;
		end else begin
			case (state)
				FETCH: if (mem_done) begin
					instr <= mem_rdata;
					pc <= pc + 1'b1;
					state <= EXECUTE;
				end
				EXECUTE: begin
					// The pc already points past this instruction.
					if (take_jump)
						pc <= jump_target;
					if (is_halt)
						state <= HALTED;
					else if (is_mem_op)
						state <= MEM_WAIT;
					else if (is_port_op)
						state <= PORT_WAIT;
					else
						state <= WRITEBACK;
				end
				MEM_WAIT: if (mem_done)
					state <= FETCH;
				PORT_WAIT: if (port_done)
					state <= WRITEBACK;
				WRITEBACK: state <= FETCH;
				default: state <= HALTED;	// HALTED is left only by reset.
			endcase
		end
	end

	// The memory request is up for the whole fetch and data access.
	assign mem_req = (state == FETCH) || (state == MEM_WAIT);
	assign mem_write = (state == MEM_WAIT) && is_store;
	assign mem_addr = (state == MEM_WAIT) ? load_addr : pc;
	assign mem_wdata = store_data;

	assign exec_en = (state == EXECUTE);
	assign port_go = (state == EXECUTE) && is_port_op;

	// A load writes its register in the cycle its data comes back.
	assign reg_we = (state == WRITEBACK) || ((state == MEM_WAIT) && mem_done && !is_store);
	assign wb_from_mem = (state == MEM_WAIT);
	assign halted = (state == HALTED);

	// Each instruction is executed in a single cycle and never twice.
	a_exec_single: assert property (@(posedge CLK) disable iff (!rst_n) exec_en |=> !exec_en)
		else $error("exec_en high for two cycles in a row");

endmodule

/* slurm16_cpu_top.sv */
/*
 * Slurm16 CPU top level.
 * Joins the memory interface, sequencer, execute unit, register
 * file and port interface to the memory and port buses.
 */

module slurm16_cpu_top import slurm16_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,

	// Memory bus, request held until ready.
	output addr_t memory_address,
	input  word_t memory_in,
	output word_t memory_out,
	output logic  memory_valid,
	output logic  memory_wr,
	input  logic  memory_ready,

	// Port bus with one-cycle strobes.
	output addr_t port_address,
	input  word_t port_in,
	output word_t port_out,
	output logic  port_rd,
	output logic  port_wr,

	output logic  halted
);

	// ------------------------------------------------------------
	// Internal nets, named as on the block ports
	// ------------------------------------------------------------

	logic mem_req, mem_write, mem_done;
	addr_t mem_addr;
	word_t mem_wdata, mem_rdata;

	word_t instr;
	logic exec_en, port_go, reg_we, wb_from_mem, port_done;
	logic is_mem_op, is_store, is_port_op, is_port_write, is_halt, take_jump;
	addr_t jump_target, load_addr, port_addr;
	word_t store_data, port_wdata, port_rdata;

	reg_sel_t a_sel, b_sel, wr_sel;
	word_t a_data, b_data, wr_data;

	// ------------------------------------------------------------
	// Blocks
	// ------------------------------------------------------------

	slurm16_cpu_memory_interface cpu_mem0 (.*);

	slurm16_cpu_sequencer cpu_seq0 (.*);

	slurm16_cpu_execute cpu_exec0 (.*);

	// The write strobe comes straight from the sequencer.
	slurm16_cpu_register_file cpu_reg0 (
		.*,
		.we(reg_we)
	);

	slurm16_cpu_port_interface cpu_prt0 (.*);

endmodule

/* slurm16_pkg.sv */
/*
 * Slurm16 shared definitions.
 * Machine widths, the word types, the instruction opcodes and the
 * states of the fetch/execute sequencer.
 */

package slurm16_pkg;

	// ------------------------------------------------------------
	// Machine widths
	// ------------------------------------------------------------

	// The machine is 16 bit with a 16 bit address bus.
	localparam int BITS = 16;
	localparam int ADDRESS_BITS = 16;

	// Sixteen registers need a four bit select.
	localparam int REGISTER_BITS = 4;

	// ------------------------------------------------------------
	// Word types
	// ------------------------------------------------------------

	typedef logic [BITS - 1:0] word_t;
	typedef logic [ADDRESS_BITS - 1:0] addr_t;
	typedef logic [REGISTER_BITS - 1:0] reg_sel_t;

	// The first instruction is fetched from this address after reset.
	localparam addr_t RESET_PC = '0;

	// Opcodes live in the top nibble of every instruction word.
	// Codes 4'hC to 4'hE are unassigned and behave as no-ops.
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_LDI  = 4'h5,
		OP_LD   = 4'h6,
		OP_ST   = 4'h7,
		OP_IN   = 4'h8,
		OP_OUT  = 4'h9,
		OP_JMP  = 4'hA,
		OP_JZ   = 4'hB,
		OP_HALT = 4'hF
	} opcode_t;

	// One instruction is in flight at a time, so the sequencer simply
	// walks through these states for each instruction.
	typedef enum logic [2:0] {
		FETCH,
		EXECUTE,
		MEM_WAIT,
		PORT_WAIT,
		WRITEBACK,
		HALTED
	} seq_state_t;

endpackage

/* tb_slurm16_cpu.sv */
/*
 * Testbench for the Slurm16 CPU subsystem.
 * Runs a preloaded program, models a port device, checks the buses
 * with concurrent assertions and the OUT values against a scoreboard.
 */

module tb_slurm16_cpu import slurm16_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	// Operands and addresses used by the program in the memory model.
	localparam word_t OPER_A = 16'h0012;
	localparam word_t OPER_B = 16'h0034;
	localparam addr_t OUT_PORT = 16'h0040;
	localparam addr_t IN_PORT = 16'h005A;
	localparam addr_t STORE_ADDR = 16'h0080;
	localparam word_t JUMP_END = 16'd31;
	localparam int HALT_TIMEOUT = 2000;

	logic  CLK;
	logic  rst_n;
	addr_t memory_address;
	word_t memory_in;
	word_t memory_out;
	logic  memory_valid;
	logic  memory_wr;
	logic  memory_ready;
	addr_t port_address;
	word_t port_in;
	word_t port_out;
	logic  port_rd;
	logic  port_wr;
	logic  halted;

	int error_count = 0;
	int out_checked = 0;
	int store_seen = 0;
	word_t expected_out [$];

	slurm16_cpu_top dut_i (.*);

	tb_slurm16_memory mem_model_i (.*);

	task automatic count_failure(input string what);
		error_count++;
		$display("%s", what);
	endtask

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		error_count++;
		$display("ERROR %s: expected 0x%h, got 0x%h", name, expected, actual);
	endtask

	// ------------------------------------------------------------
	// Clock and port device
	// ------------------------------------------------------------

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// The device answers any port read with its address XOR A5A5.
	initial begin
		port_in = '0;
		forever begin
			@(posedge CLK);
			#2 port_in = port_address ^ 16'hA5A5;
		end
	end

	// ------------------------------------------------------------
	// Bus assertions
	// ------------------------------------------------------------

	a_reset_idle: assert property (@(posedge CLK)
		!rst_n |-> !memory_valid && !port_rd && !port_wr && !halted)
		else count_failure("bus strobes or halted were active during reset");

	a_release_idle: assert property (@(posedge CLK)
		$rose(rst_n) |-> !memory_valid && !port_rd && !port_wr)
		else count_failure("bus strobes were active right after reset release");

	a_bus_held: assert property (@(posedge CLK) disable iff (!rst_n)
		memory_valid && !memory_ready |=> memory_valid && $stable(memory_address) &&
			$stable(memory_wr) && $stable(memory_out))
		else count_failure("memory request moved while memory_ready was low");

	a_store_addr: assert property (@(posedge CLK) disable iff (!rst_n)
		memory_valid && memory_ready && memory_wr |-> memory_address == STORE_ADDR)
		else report_mismatch("memory_address", STORE_ADDR, $sampled(memory_address));

	a_store_data: assert property (@(posedge CLK) disable iff (!rst_n)
		memory_valid && memory_ready && memory_wr |-> memory_out == OPER_A + OPER_B)
		else report_mismatch("memory_out", OPER_A + OPER_B, $sampled(memory_out));

	// Each OUT is one strobe to the same port.
	a_wr_single: assert property (@(posedge CLK) disable iff (!rst_n) port_wr |=> !port_wr)
		else count_failure("port_wr stayed high for more than one cycle");

	a_out_port: assert property (@(posedge CLK) disable iff (!rst_n)
		port_wr |-> port_address == OUT_PORT)
		else report_mismatch("port_address", OUT_PORT, $sampled(port_address));

	// A halted CPU stays halted and leaves both buses alone.
	a_halt_quiet: assert property (@(posedge CLK) disable iff (!rst_n)
		halted |-> !memory_valid && !port_rd && !port_wr)
		else count_failure("the CPU used a bus after it halted");

	a_halt_holds: assert property (@(posedge CLK) disable iff (!rst_n) halted |=> halted)
		else count_failure("halted dropped without a reset");

	// ------------------------------------------------------------
	// Scoreboard
	// ------------------------------------------------------------

	// Port writes and stores are sampled at the falling edge.
	always @(negedge CLK) begin
		if (rst_n && port_wr) begin
			if (expected_out.size() == 0) begin
				count_failure($sformatf("unexpected OUT of 0x%h after the last expected one",
					port_out));
			end else begin
				if (port_out !== expected_out[0])
					report_mismatch("port_out", expected_out[0], port_out);
				void'(expected_out.pop_front());
				out_checked++;
			end
		end
		if (rst_n && memory_valid && memory_ready && memory_wr)
			store_seen++;
	end

	// ------------------------------------------------------------
	// Stimulus and report
	// ------------------------------------------------------------

	initial begin
		int cycles;
		rst_n = 1'b0;
		// OUT values are listed in program order.
		expected_out.push_back(OPER_A);
		expected_out.push_back(OPER_A + OPER_B);
		expected_out.push_back(OPER_B - OPER_A);
		expected_out.push_back(OPER_A & OPER_B);
		expected_out.push_back(OPER_A | OPER_B);
		expected_out.push_back(OPER_A ^ OPER_B);
		expected_out.push_back(OPER_A + OPER_B);
		expected_out.push_back(IN_PORT ^ 16'hA5A5);
		expected_out.push_back(JUMP_END);

		repeat (10) @(posedge CLK);
		#2 rst_n = 1'b1;

		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halted) begin
			count_failure("timeout: the CPU never reached HALT");
		end else begin
			// The halt assertions watch the bus over this stretch.
			repeat (50) @(posedge CLK);
		end

		if (store_seen != 1)
			count_failure($sformatf("expected one memory store, saw %0d", store_seen));
		if (expected_out.size() != 0)
			count_failure($sformatf("%0d expected OUT values never appeared",
				expected_out.size()));

		$display("Run finished: %0d OUT values checked, %0d errors", out_checked, error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* tb_slurm16_memory.sv */
/*
 * Testbench memory model for the Slurm16 CPU.
 * Holds the test program and answers each bus request after a random
 * wait of 0 to 3 cycles, with reads and writes taking effect at ready.
 */

module tb_slurm16_memory import slurm16_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,
	input  addr_t memory_address,
	input  word_t memory_out,
	input  logic  memory_valid,
	input  logic  memory_wr,
	output word_t memory_in,
	output logic  memory_ready
);

	timeunit 1ns;
	timeprecision 1ps;

	word_t mem [0:65535];
	integer seed = 92;
	int wait_left;
	logic busy;

	// Register to register form: op, rd, ra, rb.
	function automatic word_t rr_word(opcode_t op, reg_sel_t rd, reg_sel_t ra, reg_sel_t rb);
		return {op, rd, ra, rb};
	endfunction

	// Immediate form: op, rd, imm8.
	function automatic word_t imm_word(opcode_t op, reg_sel_t rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	// Unused words decode as HALT, so a stray fetch stops the CPU.
	// The low twelve bits still mix in every address bit.
	function automatic word_t fill_word(addr_t a);
		return {4'hF, a[11:0] ^ {4'h0, a[15:8]}};
	endfunction

	// ------------------------------------------------------------
	// Test program
	// ------------------------------------------------------------

	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = fill_word(addr_t'(i));
		// ALU results, each sent to port 0x40 with an OUT.
		mem[0]  = imm_word(OP_LDI, 4'd1, 8'h12);
		mem[1]  = imm_word(OP_LDI, 4'd2, 8'h34);
		mem[2]  = imm_word(OP_LDI, 4'd15, 8'h40);
		mem[3]  = rr_word(OP_OUT, 4'd0, 4'd15, 4'd1);
		mem[4]  = rr_word(OP_ADD, 4'd3, 4'd1, 4'd2);
		mem[5]  = rr_word(OP_OUT, 4'd0, 4'd15, 4'd3);
		mem[6]  = rr_word(OP_SUB, 4'd4, 4'd2, 4'd1);
		mem[7]  = rr_word(OP_OUT, 4'd0, 4'd15, 4'd4);
		mem[8]  = rr_word(OP_AND, 4'd5, 4'd1, 4'd2);
		mem[9]  = rr_word(OP_OUT, 4'd0, 4'd15, 4'd5);
		mem[10] = rr_word(OP_OR, 4'd6, 4'd1, 4'd2);
		mem[11] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd6);
		mem[12] = rr_word(OP_XOR, 4'd7, 4'd1, 4'd2);
		mem[13] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd7);
		// Store the sum at 0x80, load it back into r9 and send it out.
		mem[14] = imm_word(OP_LDI, 4'd8, 8'h80);
		mem[15] = rr_word(OP_ST, 4'd0, 4'd8, 4'd3);
		mem[16] = rr_word(OP_LD, 4'd9, 4'd8, 4'd0);
		mem[17] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd9);
		// Read port 0x5A and echo the value.
		mem[18] = imm_word(OP_LDI, 4'd10, 8'h5A);
		mem[19] = rr_word(OP_IN, 4'd11, 4'd10, 4'd0);
		mem[20] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd11);
		// r14 marks the OUTs that the jumps must skip.
		mem[21] = imm_word(OP_LDI, 4'd14, 8'hEE);
		mem[22] = rr_word(OP_SUB, 4'd12, 4'd1, 4'd1);
		mem[23] = imm_word(OP_LDI, 4'd13, 8'd27);
		mem[24] = rr_word(OP_JZ, 4'd0, 4'd13, 4'd0);
		mem[25] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd14);
		mem[26] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd14);
		mem[27] = imm_word(OP_LDI, 4'd13, 8'd31);
		mem[28] = rr_word(OP_JMP, 4'd0, 4'd13, 4'd0);
		mem[29] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd14);
		mem[30] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd14);
		mem[31] = rr_word(OP_OUT, 4'd0, 4'd15, 4'd13);
		mem[32] = rr_word(OP_HALT, 4'd0, 4'd0, 4'd0);
	end

	// ------------------------------------------------------------
	// Bus responder
	// ------------------------------------------------------------

	// Bus signals are read at the edge and driven 2 ns after it.
	initial begin
		memory_ready = 1'b0;
		memory_in = '0;
		busy = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge CLK);
			if (!rst_n) begin
				busy = 1'b0;
			end else if (memory_valid && memory_ready) begin
				// The transfer completes at this edge.
				if (memory_wr)
					mem[memory_address] = memory_out;
				busy = 1'b0;
				#2 memory_ready = 1'b0;
			end else if (memory_valid) begin
				// A new request draws its own wait.
				if (!busy) begin
					busy = 1'b1;
					wait_left = $random(seed) & 3;
				end
				if (wait_left == 0) begin
					#2;
					memory_in = mem[memory_address];
					memory_ready = 1'b1;
				end else begin
					wait_left--;
				end
			end
		end
	end

endmodule
